// File: board_pkg.sv
package board_pkg;

	// ====================
	// bus geometry
	// ====================
	localparam int AXI_ADDR_W = 30;	// byte address from the processor bridge
	localparam int AXI_DATA_W = 32;
	localparam int AXI_STRB_W = AXI_DATA_W / 8;	// one strobe per byte lane

	localparam int REG_IDX_LSB = 2;	// word aligned, low two bits pick the byte
	localparam int REG_IDX_W = 3;	// eight word slots, six in use
	localparam int REG_SLOTS = 1 << REG_IDX_W;

	localparam logic [1:0] RESP_OKAY = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

	// ====================
	// version word
	// ====================
	localparam logic [7:0] FPGA_DEV = 8'h02;
	localparam logic [7:0] FPGA_FUN = 8'h01;
	localparam logic [15:0] FPGA_REV = 16'h0001;
	localparam logic [31:0] FPGA_VERSION = {FPGA_DEV, FPGA_FUN, FPGA_REV};

	// ====================
	// board pins
	// ====================
	localparam int N_SW = 4;	// active-low slide switches
	localparam int N_GPIO = 4;	// header gpio
	localparam int N_ULED = 3;	// leds 2..4, led 1 is the heartbeat
	localparam int JP5_W = 20;
	localparam int JP4_LANES = 6;	// per diff group
	localparam int JP4_W = 4 * JP4_LANES;

	localparam logic [3:0] HB_PAT_A = 4'b0000;	// first flash of the double blink
	localparam logic [3:0] HB_PAT_B = 4'b0010;	// second flash

	typedef enum logic [REG_IDX_W-1:0] {
		REG_VERSION = 3'd0,	// ro
		REG_SWITCH = 3'd1,	// ro, synced and inverted
		REG_GPIO = 3'd2,
		REG_LED = 3'd3,
		REG_JP5 = 3'd4,
		REG_JP4 = 3'd5	// last mapped word
	} reg_idx_e;

	typedef struct packed { logic [AXI_ADDR_W-1:0] addr; } axi_aw_t;
	typedef struct packed { logic [AXI_DATA_W-1:0] data; logic [AXI_STRB_W-1:0] strb; } axi_w_t;
	typedef struct packed { logic [1:0] resp; } axi_b_t;
	typedef struct packed { logic [AXI_ADDR_W-1:0] addr; } axi_ar_t;
	typedef struct packed { logic [AXI_DATA_W-1:0] data; logic [1:0] resp; } axi_r_t;

	typedef struct packed {
		logic [AXI_ADDR_W-1:0] addr;
		logic [AXI_DATA_W-1:0] data;
		logic [AXI_STRB_W-1:0] strb;
	} reg_wr_t;	// one register write strobe

	typedef struct packed { logic [AXI_DATA_W-1:0] data; logic err; } reg_rd_t;

	typedef struct packed {
		logic [JP4_LANES-1:0] txp;	// msb field
		logic [JP4_LANES-1:0] txn;
		logic [JP4_LANES-1:0] rxp;
		logic [JP4_LANES-1:0] rxn;	// register bits 5:0
	} jp4_t;

	typedef struct packed {
		logic [3:0] led;
		logic [N_GPIO-1:0] gpio;
		logic [JP5_W-1:0] jp5;
		jp4_t jp4;
	} board_pins_t;

endpackage

// File: board_regs.sv
`timescale 1ns/1ps

module board_regs import board_pkg::*; (
	input logic axi_clk,
	input logic rst,
	input reg_wr_t wr,
	input logic wr_en,
	output logic wr_err,	// comb, from wr.addr
	input axi_ar_t rd_addr,
	input logic rd_en,
	output reg_rd_t rd,	// loaded on rd_en only
	input logic [N_SW-1:0] sw_n,	// async board switches
	output logic [N_GPIO-1:0] gpio,
	output logic [N_ULED-1:0] uled,
	output logic [JP5_W-1:0] jp5,
	output jp4_t jp4
);

	logic [N_SW-1:0] sw_meta;	// first sync stage
	logic [N_SW-1:0] sw_sync;	// second stage, already inverted
	logic [REG_SLOTS-1:0][AXI_DATA_W-1:0] words;	// zero-extended view of every slot
	reg_idx_e wr_idx;
	reg_idx_e rd_idx;
	logic rd_err;
	logic [AXI_DATA_W-1:0] merged;	// old word with strobed bytes replaced

	// out of map if anything above the index is set, or index past jp4
	function automatic logic addr_bad(input logic [AXI_ADDR_W-1:0] addr);
		logic [REG_IDX_W-1:0] idx;
		logic upper;
		idx = addr[REG_IDX_LSB +: REG_IDX_W];
		upper = |addr[AXI_ADDR_W-1:REG_IDX_LSB+REG_IDX_W];
		return upper || (idx > REG_JP4);
	endfunction

	// byte lane merge under wstrb
	function automatic logic [AXI_DATA_W-1:0] strb_merge(
		input logic [AXI_DATA_W-1:0] old,
		input logic [AXI_DATA_W-1:0] data,
		input logic [AXI_STRB_W-1:0] strb
	);
		logic [AXI_DATA_W-1:0] res;
		res = old;
		for (int i = 0; i < AXI_STRB_W; i++)
		begin
			if (strb[i])
				res[8*i +: 8] = data[8*i +: 8];
		end
		return res;
	endfunction

	// ====================
	// switch sync
	// ====================
	always_ff @(posedge axi_clk)
	begin
		if (rst)
		begin
			sw_meta <= '0;
			sw_sync <= '0;
		end
		else
		begin
			sw_meta <= ~sw_n;	// invert at the pin, 1 = on
			sw_sync <= sw_meta;
		end
	end

	// ====================
	// decode
	// ====================
	assign wr_idx = reg_idx_e'(wr.addr[REG_IDX_LSB +: REG_IDX_W]);
	assign rd_idx = reg_idx_e'(rd_addr.addr[REG_IDX_LSB +: REG_IDX_W]);
	assign wr_err = addr_bad(wr.addr);	// back to the port same cycle
	assign rd_err = addr_bad(rd_addr.addr);

	always_comb
	begin
		words = '0;	// unused slots and upper bits read zero
		words[REG_VERSION] = FPGA_VERSION;
		words[REG_SWITCH][N_SW-1:0] = sw_sync;
		words[REG_GPIO][N_GPIO-1:0] = gpio;
		words[REG_LED][N_ULED-1:0] = uled;
		words[REG_JP5][JP5_W-1:0] = jp5;
		words[REG_JP4][JP4_W-1:0] = jp4;
	end

	assign merged = strb_merge(words[wr_idx], wr.data, wr.strb);

	// ====================
	// write side
	// ====================
	always_ff @(posedge axi_clk)
	begin
		if (rst)
		begin
			gpio <= '0;
			uled <= '0;
			jp5 <= '0;
			jp4 <= '0;
		end
		else if (wr_en && !wr_err)
		begin
			case (wr_idx)
				REG_GPIO: gpio <= merged[N_GPIO-1:0];	// bits above width dropped
				REG_LED: uled <= merged[N_ULED-1:0];
				REG_JP5: jp5 <= merged[JP5_W-1:0];
				REG_JP4: jp4 <= merged[JP4_W-1:0];	// rxn in bits 5:0
				default: ;	// version and switch are read only, write is ignored
			endcase
		end
	end

	// ====================
	// read side
	// ====================
	always_ff @(posedge axi_clk)
	begin
		if (rst)
		begin
			rd <= '0;
		end
		else if (rd_en)
		begin
			rd.data <= rd_err ? '0 : words[rd_idx];	// bad address reads zero
			rd.err <= rd_err;
		end
	end

	// a flagged write must not touch any pin register
	a_no_bad_write: assert property (@(posedge axi_clk) disable iff (rst)
		(wr_en && wr_err) |=> ($stable(gpio) && $stable(uled) && $stable(jp5) && $stable(jp4)))
		else $error("write landed on an out-of-map address");

endmodule

// File: axi_lite_port.sv
`timescale 1ns/1ps

module axi_lite_port import board_pkg::*; (
	input logic axi_clk,
	input logic rst,

	// ====================
	// axi-lite slave
	// ====================
	input axi_aw_t aw,
	input logic awvalid,
	output logic awready,
	input axi_w_t w,
	input logic wvalid,
	output logic wready,
	output axi_b_t b,
	output logic bvalid,
	input logic bready,
	input axi_ar_t ar,
	input logic arvalid,
	output logic arready,
	output axi_r_t r,
	output logic rvalid,
	input logic rready,

	// ====================
	// register side
	// ====================
	output reg_wr_t wr,
	output logic wr_en,	// apply on this edge
	input logic wr_err,	// comb decode result for wr.addr
	output axi_ar_t rd_addr,
	output logic rd_en,	// load rd on this edge
	input reg_rd_t rd	// held until the next rd_en
);

	logic wr_take;	// aw and w accepted together
	logic rd_take;

	// ====================
	// write channel
	// ====================
	// aw and w only move as a pair, and never while a b is outstanding
	assign wr_take = awvalid && wvalid && !bvalid;
	assign awready = wr_take;
	assign wready = wr_take;

	assign wr_en = wr_take;
	assign wr.addr = aw.addr;
	assign wr.data = w.data;
	assign wr.strb = w.strb;

	always_ff @(posedge axi_clk)
	begin
		if (rst)
		begin
			bvalid <= 1'b0;
			b <= '0;
		end
		else if (wr_take)
		begin
			bvalid <= 1'b1;	// response one cycle after acceptance
			b.resp <= wr_err ? RESP_SLVERR : RESP_OKAY;
		end
		else if (bready)
		begin
			bvalid <= 1'b0;	// taken, or never there
		end
	end

	// ====================
	// read channel
	// ====================
	assign rd_take = arvalid && !rvalid;	// one read in flight at most
	assign arready = rd_take;
	assign rd_en = rd_take;
	assign rd_addr = ar;

	always_ff @(posedge axi_clk)
	begin
		if (rst)
		begin
			rvalid <= 1'b0;
		end
		else if (rd_take)
		begin
			rvalid <= 1'b1;	// rd gets loaded on the same edge
		end
		else if (rready)
		begin
			rvalid <= 1'b0;
		end
	end

	// rd is the holding register, it cannot change while rvalid blocks rd_en
	assign r.data = rd.data;	// zero on decode error
	assign r.resp = rd.err ? RESP_SLVERR : RESP_OKAY;

	// ====================
	// checks
	// ====================
	a_b_hold: assert property (@(posedge axi_clk) disable iff (rst)
		(bvalid && !bready) |=> (bvalid && $stable(b)))
		else $error("b response dropped or changed before bready");

	a_r_hold: assert property (@(posedge axi_clk) disable iff (rst)
		(rvalid && !rready) |=> rvalid)
		else $error("rvalid dropped before rready");

	a_r_stable: assert property (@(posedge axi_clk) disable iff (rst)
		(rvalid && !rready) |=> $stable(r))
		else $error("r payload changed while stalled");

endmodule

// File: heartbeat_blink.sv
`timescale 1ns/1ps

module heartbeat_blink import board_pkg::*; #(
	parameter int HB_MSB = 26	// period is 2**(HB_MSB+1) clocks
) (
	input logic axi_clk,
	input logic rst,
	output logic blink	// registered, one cycle behind the count
);

	logic [HB_MSB:0] cnt;	// free running
	logic [3:0] top;	// four msbs of the count
	logic hit;

	// ====================
	// counter
	// ====================
	always_ff @(posedge axi_clk)
	begin
		if (rst)
			cnt <= '0;	// reads zero on the first edge out of reset
		else
			cnt <= cnt + 1'b1;
	end

	// ====================
	// pattern decode
	// ====================
	assign top = cnt[HB_MSB -: 4];
	assign hit = (top == HB_PAT_A) || (top == HB_PAT_B);	// two short flashes per period

	always_ff @(posedge axi_clk)
	begin
		if (rst)
			blink <= 1'b0;
		else
			blink <= hit;
	end

endmodule

// File: board_top.sv
`timescale 1ns/1ps

module board_top import board_pkg::*; #(
	parameter int HB_MSB = 26	// top counter bit, sets the blink period
) (
	input logic axi_clk,
	input logic rst,	// sync, active high

	// ====================
	// axi-lite slave
	// ====================
	input axi_aw_t aw,
	input logic awvalid,
	output logic awready,
	input axi_w_t w,
	input logic wvalid,
	output logic wready,
	output axi_b_t b,
	output logic bvalid,
	input logic bready,
	input axi_ar_t ar,
	input logic arvalid,
	output logic arready,
	output axi_r_t r,
	output logic rvalid,
	input logic rready,

	// ====================
	// board pins
	// ====================
	input logic [N_SW-1:0] sw_n,	// low when switched on
	output board_pins_t pins
);

	reg_wr_t wr;	// write strobe toward the register file
	logic wr_en;
	logic wr_err;	// decode error, back to the port
	axi_ar_t rd_addr;
	logic rd_en;
	reg_rd_t rd;	// registered read word
	logic [N_GPIO-1:0] gpio;
	logic [N_ULED-1:0] uled;
	logic [JP5_W-1:0] jp5;
	jp4_t jp4;
	logic hb;	// heartbeat led

	axi_lite_port u_port (
		.axi_clk(axi_clk), .rst(rst),
		.aw(aw), .awvalid(awvalid), .awready(awready),
		.w(w), .wvalid(wvalid), .wready(wready),
		.b(b), .bvalid(bvalid), .bready(bready),
		.ar(ar), .arvalid(arvalid), .arready(arready),
		.r(r), .rvalid(rvalid), .rready(rready),
		.wr(wr), .wr_en(wr_en), .wr_err(wr_err),
		.rd_addr(rd_addr), .rd_en(rd_en), .rd(rd)
	);

	board_regs u_regs (
		.axi_clk(axi_clk), .rst(rst),
		.wr(wr), .wr_en(wr_en), .wr_err(wr_err),
		.rd_addr(rd_addr), .rd_en(rd_en), .rd(rd),
		.sw_n(sw_n),
		.gpio(gpio), .uled(uled), .jp5(jp5), .jp4(jp4)
	);

	heartbeat_blink #(
		.HB_MSB(HB_MSB)
	) u_hb (
		.axi_clk(axi_clk),
		.rst(rst),
		.blink(hb)
	);

	// pin assembly, led 1 is the heartbeat
	assign pins.led = {uled, hb};	// leds 2..4 from reg bits 2:0
	assign pins.gpio = gpio;
	assign pins.jp5 = jp5;
	assign pins.jp4 = jp4;

endmodule

// File: tb_board_top.sv
`timescale 1ns/1ps

module tb_board_top import board_pkg::*; ();

	localparam int TIMEOUT_CYC = 20000;	// ~200 transfers plus 4 blink periods plus margin
	localparam int HB_PERIOD = 256;	// 2**(7+1) with HB_MSB of 7

	typedef struct packed {
		logic is_rd;
		logic [AXI_ADDR_W-1:0] addr;
		logic [AXI_DATA_W-1:0] data;	// zero for writes
		logic [1:0] resp;
	} rsp_t;

	logic axi_clk;
	logic rst;
	axi_aw_t aw;
	logic awvalid;
	logic awready;
	axi_w_t w;
	logic wvalid;
	logic wready;
	axi_b_t b;
	logic bvalid;
	logic bready;
	axi_ar_t ar;
	logic arvalid;
	logic arready;
	axi_r_t r;
	logic rvalid;
	logic rready;
	logic [N_SW-1:0] sw_n;
	board_pins_t pins;

	logic [N_GPIO-1:0] sh_gpio;	// shadow registers
	logic [N_ULED-1:0] sh_led;
	logic [JP5_W-1:0] sh_jp5;
	logic [23:0] sh_jp4;
	logic [N_SW-1:0] sh_sw;	// switches as they should read, 1 = on
	rsp_t got_q[$];	// responses seen on the bus
	rsp_t exp_q[$];	// responses from the model
	int n_err = 0;
	int n_chk = 0;
	int cyc = 0;
	logic [7:0] hb_cnt;	// heartbeat counter model
	logic hb_exp;
	logic hb_live = 1'b0;

	initial
	begin
		axi_clk = 1'b0;
		forever #2 axi_clk = ~axi_clk;	// 4 ns period
	end

	board_top #(
		.HB_MSB(7)	// short blink period for sim
	) DUT (
		.axi_clk(axi_clk), .rst(rst),
		.aw(aw), .awvalid(awvalid), .awready(awready),
		.w(w), .wvalid(wvalid), .wready(wready),
		.b(b), .bvalid(bvalid), .bready(bready),
		.ar(ar), .arvalid(arvalid), .arready(arready),
		.r(r), .rvalid(rvalid), .rready(rready),
		.sw_n(sw_n), .pins(pins)
	);

	// ====================
	// reference model
	// ====================
	function automatic rsp_t model_rsp(input logic is_rd, input logic [AXI_ADDR_W-1:0] addr);
		rsp_t res;
		logic bad;
		logic [2:0] idx;
		res = '0;
		idx = addr[4:2];	// word index
		bad = (addr[AXI_ADDR_W-1:5] != '0) || (idx > 3'd5);	// upper bits or past jp4
		res.is_rd = is_rd;
		res.addr = addr;
		res.resp = bad ? RESP_SLVERR : RESP_OKAY;
		if (is_rd && !bad)
		begin
			case (idx)
				3'd0: res.data = {8'h02, 8'h01, 16'h0001};	// dev, fun, rev
				3'd1: res.data = {28'h0, sh_sw};
				3'd2: res.data = {28'h0, sh_gpio};
				3'd3: res.data = {29'h0, sh_led};
				3'd4: res.data = {12'h0, sh_jp5};
				3'd5: res.data = {8'h0, sh_jp4};
				default: res.data = '0;
			endcase
		end
		return res;
	endfunction

	task automatic update_shadow(input logic [AXI_ADDR_W-1:0] addr, input logic [31:0] data,
		input logic [3:0] strb);
		logic [31:0] cur;
		int i;
		if (addr[AXI_ADDR_W-1:5] != '0)
			return;	// out of map so nothing moves
		case (addr[4:2])
			3'd2: cur = {28'h0, sh_gpio};
			3'd3: cur = {29'h0, sh_led};
			3'd4: cur = {12'h0, sh_jp5};
			3'd5: cur = {8'h0, sh_jp4};
			default: return;	// ro words and holes
		endcase
		for (i = 0; i < 4; i++)
		begin
			if (strb[i])
				cur[8*i +: 8] = data[8*i +: 8];	// byte lane
		end
		case (addr[4:2])
			3'd2: sh_gpio = cur[3:0];
			3'd3: sh_led = cur[2:0];
			3'd4: sh_jp5 = cur[19:0];
			default: sh_jp4 = cur[23:0];
		endcase
	endtask

	task automatic check_pins();
		logic [50:0] got;
		logic [50:0] exp;
		got = {pins.led[3:1], pins.gpio, pins.jp5, pins.jp4};	// heartbeat left out
		exp = {sh_led, sh_gpio, sh_jp5, sh_jp4};
		n_chk++;
		assert (got === exp)
		else
		begin
			n_err++;
			$display("Error: pins got %h exp %h", got, exp);
		end
	endtask

	// ====================
	// bus tasks
	// ====================
	task automatic write_word(input logic [AXI_ADDR_W-1:0] addr, input logic [31:0] data,
		input logic [3:0] strb, input int stall, output logic [1:0] resp);
		logic acc;
		int i;
		aw.addr = addr;
		w.data = data;
		w.strb = strb;
		awvalid = 1'b1;
		wvalid = 1'b1;
		acc = 1'b0;
		while (!acc)
		begin
			@(negedge axi_clk);
			acc = awready && wready;	// decides the next edge
			@(posedge axi_clk);
			#1;
		end
		if (stall == 0)
		begin
			awvalid = 1'b0;
			wvalid = 1'b0;
			bready = 1'b1;
		end
		@(negedge axi_clk);
		n_chk++;
		assert (bvalid)
		else
		begin
			n_err++;
			$display("bvalid did not rise one cycle after the write was accepted");
		end
		resp = b.resp;
		for (i = 0; i < stall; i++)
		begin
			@(posedge axi_clk);
			#1;
			@(negedge axi_clk);
			n_chk++;
			assert (bvalid && b.resp === resp)
			else
			begin
				n_err++;
				$display("write response dropped or changed while bready was low");
			end
			assert (!awready && !wready)	// aw/w still offered here
			else
			begin
				n_err++;
				$display("a new write was accepted while a response was pending");
			end
		end
		if (stall != 0)
		begin
			@(posedge axi_clk);
			#1;
			awvalid = 1'b0;
			wvalid = 1'b0;
			bready = 1'b1;
		end
		@(posedge axi_clk);	// b taken here
		#1;
		bready = 1'b0;
	endtask

	task automatic read_word(input logic [AXI_ADDR_W-1:0] addr, input int stall,
		output logic [31:0] data, output logic [1:0] resp);
		logic acc;
		int i;
		ar.addr = addr;
		arvalid = 1'b1;
		acc = 1'b0;
		while (!acc)
		begin
			@(negedge axi_clk);
			acc = arready;
			@(posedge axi_clk);
			#1;
		end
		if (stall == 0)
		begin
			arvalid = 1'b0;
			rready = 1'b1;
		end
		@(negedge axi_clk);
		n_chk++;
		assert (rvalid)
		else
		begin
			n_err++;
			$display("rvalid did not rise one cycle after the read was accepted");
		end
		data = r.data;
		resp = r.resp;
		for (i = 0; i < stall; i++)
		begin
			@(posedge axi_clk);
			#1;
			@(negedge axi_clk);
			n_chk++;
			assert (rvalid && r.data === data && r.resp === resp)
			else
			begin
				n_err++;
				$display("read response dropped or changed while rready was low");
			end
			assert (!arready)	// ar still offered
			else
			begin
				n_err++;
				$display("a new read was accepted while a response was pending");
			end
		end
		if (stall != 0)
		begin
			@(posedge axi_clk);
			#1;
			arvalid = 1'b0;
			rready = 1'b1;
		end
		@(posedge axi_clk);
		#1;
		rready = 1'b0;
	endtask

	task automatic write_expect(input logic [AXI_ADDR_W-1:0] addr, input logic [31:0] data,
		input logic [3:0] strb, input int stall);
		logic [1:0] resp;
		rsp_t got;
		exp_q.push_back(model_rsp(1'b0, addr));	// before the shadow moves
		write_word(addr, data, strb, stall, resp);
		got = '0;
		got.addr = addr;
		got.resp = resp;
		got_q.push_back(got);
		update_shadow(addr, data, strb);
		check_pins();
	endtask

	task automatic read_expect(input logic [AXI_ADDR_W-1:0] addr, input int stall);
		logic [31:0] data;
		logic [1:0] resp;
		rsp_t got;
		exp_q.push_back(model_rsp(1'b1, addr));
		read_word(addr, stall, data, resp);
		got.is_rd = 1'b1;
		got.addr = addr;
		got.data = data;
		got.resp = resp;
		got_q.push_back(got);
	endtask

	// ====================
	// compare and monitors
	// ====================
	always @(negedge axi_clk)
	begin
		rsp_t g;
		rsp_t e;
		while (got_q.size() > 0 && exp_q.size() > 0)
		begin
			g = got_q.pop_front();
			e = exp_q.pop_front();
			n_chk++;
			assert (g.resp === e.resp)
			else
			begin
				n_err++;
				$display("Error: %s addr=%h got %h exp %h", g.is_rd ? "r.resp" : "b.resp",
					g.addr, g.resp, e.resp);
			end
			if (g.is_rd)
			begin
				n_chk++;
				assert (g.data === e.data)
				else
				begin
					n_err++;
					$display("Error: r.data addr=%h got %h exp %h", g.addr, g.data, e.data);
				end
			end
		end
	end

	always @(posedge axi_clk)
	begin
		if (rst)
		begin
			hb_cnt <= '0;
			hb_exp <= 1'b0;
		end
		else
		begin
			hb_exp <= (hb_cnt[7:4] == 4'h0) || (hb_cnt[7:4] == 4'h2);	// double flash
			hb_cnt <= hb_cnt + 8'd1;
		end
		hb_live <= 1'b1;	// model valid from the first edge
	end

	always @(negedge axi_clk)
	begin
		if (hb_live)
		begin
			n_chk++;
			assert (pins.led[0] === hb_exp)
			else
			begin
				n_err++;
				$display("Error: pins.led[0] got %h exp %h", pins.led[0], hb_exp);
			end
		end
	end

	always @(posedge axi_clk)
	begin
		cyc <= cyc + 1;
		if (cyc >= TIMEOUT_CYC)
		begin
			$display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYC);
			$display("checks: %0d  errors: %0d", n_chk, n_err + 1);
			$display("Test failures found");
			$finish;
		end
	end

	// ====================
	// stimulus
	// ====================
	initial
	begin
		logic [AXI_ADDR_W-1:0] addr;
		logic [24:0] upper;
		logic [2:0] idx;
		void'($urandom(32'hd9e30fd1));
		rst = 1'b1;
		aw = '0;
		w = '0;
		ar = '0;
		awvalid = 1'b0;
		wvalid = 1'b0;
		bready = 1'b0;
		arvalid = 1'b0;
		rready = 1'b0;
		sw_n = 4'hf;	// all switches off
		sh_gpio = '0;
		sh_led = '0;
		sh_jp5 = '0;
		sh_jp4 = '0;
		sh_sw = '0;
		repeat (8) @(posedge axi_clk);
		#1;
		rst = 1'b0;

		read_expect(30'h0, 0);	// version word
		write_expect(30'h0, 32'hffff_ffff, 4'hf, 0);
		read_expect(30'h0, 0);

		repeat (40)	// strobed writes to the rw words
		begin
			idx = 3'(2 + $urandom % 4);
			addr = {25'h0, idx, 2'b00};
			write_expect(addr, $urandom, 4'($urandom), 0);
			read_expect(addr, 0);
		end

		repeat (8)	// switches through the synchronizer
		begin
			sw_n = 4'($urandom);
			sh_sw = ~sw_n;
			repeat (4) @(posedge axi_clk);
			#1;
			read_expect({25'h0, 3'd1, 2'b00}, 0);
		end

		repeat (12)	// holes and upper address bits
		begin
			if ($urandom % 2 == 0)
			begin
				addr = {25'h0, 3'(6 + $urandom % 2), 2'b00};
			end
			else
			begin
				upper = 25'($urandom);
				if (upper == '0)
					upper = 25'h1;
				addr = {upper, 3'($urandom), 2'b00};
			end
			write_expect(addr, $urandom, 4'hf, 0);
			read_expect(addr, 0);
		end

		repeat (20)	// back-pressure on b and r
		begin
			idx = 3'($urandom % 6);
			addr = {25'h0, idx, 2'b00};
			write_expect(addr, $urandom, 4'($urandom), int'(1 + $urandom % 6));
			read_expect(addr, int'(1 + $urandom % 6));
		end

		repeat (4 * HB_PERIOD) @(posedge axi_clk);	// heartbeat monitor keeps running
		repeat (2) @(posedge axi_clk);	// let the compare queue drain

		$display("checks: %0d  errors: %0d", n_chk, n_err);
		if (n_err == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

// File: board_top.f
board_pkg.sv
board_regs.sv
axi_lite_port.sv
heartbeat_blink.sv
board_top.sv
tb_board_top.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := tb_board_top
FLIST     := board_top.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FLIST))
PASS_MSG  := All tests passed!

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
